// ==== source/rv64_pkg.sv ====
`default_nettype none

package rv64_pkg;

  localparam int XLEN     = 64;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [31:0]     instr_t;
  typedef logic [3:0]      alu_op_t;

  // --------------------
  // ALU operations.
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;

  // --------------------
  // Major opcodes.
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 groups shared by OP and OP-IMM.
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam xlen_t REG_RESET_VALUE = 64'h0;

endpackage

`default_nettype wire

// ==== source/rv64_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv64_reg_file (
  input  logic                clk,
  input  logic                rst,

  input  logic                wr_en,
  input  rv64_pkg::reg_addr_t wr_addr,
  input  rv64_pkg::xlen_t     wr_data,

  input  rv64_pkg::reg_addr_t rd1_addr,
  input  rv64_pkg::reg_addr_t rd2_addr,
  output rv64_pkg::xlen_t     rd1_data,
  output rv64_pkg::xlen_t     rd2_data
);

  import rv64_pkg::*;

  xlen_t regs [NUM_REGS];
  logic  wr_ok;

  // x0 is hardwired, so its writes are dropped here.
  assign wr_ok = wr_en && (wr_addr != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= REG_RESET_VALUE;
      end
    end else if (wr_ok) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Both read ports are asynchronous.
  assign rd1_data = regs[rd1_addr];
  assign rd2_data = regs[rd2_addr];

  // --------------------
  a_x0_reads_zero: assert property (
    @(posedge clk) disable iff (rst)
    ((rd1_addr == '0) |-> (rd1_data == '0)) and ((rd2_addr == '0) |-> (rd2_data == '0))
  ) else $error("x0 read returned %h / %h", rd1_data, rd2_data);

endmodule

`default_nettype wire

// ==== source/rv64_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv64_decoder (
  input  rv64_pkg::instr_t    instr,

  output rv64_pkg::reg_addr_t rs1,
  output rv64_pkg::reg_addr_t rs2,
  output rv64_pkg::reg_addr_t rd,
  output rv64_pkg::xlen_t     imm,
  output rv64_pkg::alu_op_t   alu_op,
  output logic                use_imm,
  output logic                writes_rd,
  output logic                illegal
);

  import rv64_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;
  logic       is_shift;
  logic       r_funct7_ok;
  logic       shamt_ok;
  alu_op_t    f3_op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  // Bit 30 picks sub / sra.
  assign alt      = instr[30];
  assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);

  // Register ops allow only bit 30, and only for add/sub and srl/sra.
  assign r_funct7_ok = ({instr[31], instr[29:25]} == 6'b0) &&
                       (!alt || funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA);

  // RV64 shift immediates are 6 bits wide, so bit 25 belongs to shamt.
  assign shamt_ok = ({instr[31], instr[29:26]} == 5'b0) &&
                    (!alt || funct3 == F3_SRL_SRA);

  always_comb begin
    case (funct3)
      F3_ADD_SUB: f3_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
      F3_SLL:     f3_op = ALU_SLL;
      F3_SLT:     f3_op = ALU_SLT;
      F3_SLTU:    f3_op = ALU_SLTU;
      F3_XOR:     f3_op = ALU_XOR;
      F3_SRL_SRA: f3_op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      f3_op = ALU_OR;
      F3_AND:     f3_op = ALU_AND;
    endcase
  end

  // --------------------
  always_comb begin
    imm     = {{(XLEN-12){instr[31]}}, instr[31:20]};
    alu_op  = ALU_ADD;
    use_imm = 1'b0;
    illegal = 1'b1;

    case (opcode)
      OPC_OP: begin
        alu_op  = f3_op;
        illegal = !r_funct7_ok;
      end
      OPC_OP_IMM: begin
        alu_op  = f3_op;
        use_imm = 1'b1;
        illegal = is_shift && !shamt_ok;
      end
      OPC_LUI: begin
        imm     = {{(XLEN-32){instr[31]}}, instr[31:12], 12'b0};
        alu_op  = ALU_PASS_B;
        use_imm = 1'b1;
        illegal = 1'b0;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    // Every supported instruction writes rd.
    writes_rd = !illegal;
  end

endmodule

`default_nettype wire

// ==== source/rv64_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv64_alu (
  input  rv64_pkg::alu_op_t op,
  input  rv64_pkg::xlen_t   a,
  input  rv64_pkg::xlen_t   b,
  output rv64_pkg::xlen_t   result
);

  import rv64_pkg::*;

  logic [5:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[5:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = xlen_t'($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/rv64_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv64_exec_core (
  input  logic                clk,
  input  logic                rst,

  input  logic                instr_valid,
  input  rv64_pkg::instr_t    instr,

  output logic                retire_valid,
  output logic                retire_illegal,
  output rv64_pkg::reg_addr_t retire_rd,
  output rv64_pkg::xlen_t     retire_data
);

  import rv64_pkg::*;

  // Decode stage.
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  xlen_t     imm;
  alu_op_t   alu_op;
  logic      use_imm;
  logic      writes_rd;
  logic      illegal;

  xlen_t     rd1_data;
  xlen_t     rd2_data;
  xlen_t     op_a;
  xlen_t     op_b;

  // Execute stage.
  logic      ex_valid;
  logic      ex_writes_rd;
  logic      ex_illegal;
  reg_addr_t ex_rd;
  alu_op_t   ex_alu_op;
  xlen_t     ex_a;
  xlen_t     ex_b;
  xlen_t     alu_result;
  logic      rf_wr_en;

  rv64_decoder rv64_decoder_i (
    .instr     (instr),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .writes_rd (writes_rd),
    .illegal   (illegal)
  );

  rv64_reg_file rv64_reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (rf_wr_en),
    .wr_addr  (ex_rd),
    .wr_data  (alu_result),
    .rd1_addr (rs1),
    .rd2_addr (rs2),
    .rd1_data (rd1_data),
    .rd2_data (rd2_data)
  );

  // --------------------
  // Forward the executing result when it targets a source register.
  function automatic logic fwd_hit(input reg_addr_t src);
    return ex_valid && ex_writes_rd && (ex_rd != '0) && (ex_rd == src);
  endfunction

  assign op_a = fwd_hit(rs1) ? alu_result : rd1_data;
  assign op_b = use_imm ? imm : (fwd_hit(rs2) ? alu_result : rd2_data);

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid     <= 1'b0;
      ex_writes_rd <= 1'b0;
      ex_illegal   <= 1'b0;
    end else begin
      ex_valid     <= instr_valid;
      ex_writes_rd <= instr_valid && writes_rd;
      ex_illegal   <= instr_valid && illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      ex_rd     <= rd;
      ex_alu_op <= alu_op;
      ex_a      <= op_a;
      ex_b      <= op_b;
    end
  end

  rv64_alu rv64_alu_i (
    .op     (ex_alu_op),
    .a      (ex_a),
    .b      (ex_b),
    .result (alu_result)
  );

  // --------------------
  assign rf_wr_en       = ex_valid && ex_writes_rd;
  assign retire_valid   = ex_valid;
  assign retire_illegal = ex_illegal;
  assign retire_rd      = ex_rd;
  assign retire_data    = alu_result;

  a_idle_after_reset: assert property (@(posedge clk) rst |=> !retire_valid)
    else $error("retire_valid high right after reset");

  // An illegal word must never reach the register file.
  a_no_illegal_write: assert property (
    @(posedge clk) disable iff (rst) (ex_valid && ex_illegal) |-> !rf_wr_en
  ) else $error("register write from illegal instruction, rd %0d", ex_rd);

endmodule

`default_nettype wire

// ==== dv/rv64_exec_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv64_exec_core_tb;

  import rv64_pkg::*;

  localparam int          CLK_PERIOD     = 10;
  localparam int          N_INSTR        = 400;
  localparam int          TIMEOUT_CYCLES = NUM_REGS + 2 * N_INSTR + 40;
  localparam logic [31:0] SEED           = 32'h5b2d_60fb;

  // Expected retire record holds valid, illegal, rd and data.
  typedef logic [70:0] retire_rec_t;

  logic      clk;
  logic      rst;
  logic      instr_valid;
  instr_t    instr;
  logic      retire_valid;
  logic      retire_illegal;
  reg_addr_t retire_rd;
  xlen_t     retire_data;

  logic        exp_valid;
  logic        exp_illegal;
  reg_addr_t   exp_rd;
  xlen_t       exp_data;
  retire_rec_t expected_q [$];
  xlen_t       shadow [NUM_REGS];
  int          error_count;

  rv64_exec_core rv64_exec_core_i (
    .clk            (clk),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .retire_valid   (retire_valid),
    .retire_illegal (retire_illegal),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_mismatch(input string name, input xlen_t got, input xlen_t exp);
    error_count++;
    $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
  endtask

  // --------------------
  a_retire_valid: assert property (@(posedge clk) disable iff (rst) retire_valid == exp_valid)
    else report_mismatch("retire_valid", xlen_t'($sampled(retire_valid)), xlen_t'(exp_valid));

  a_retire_illegal: assert property (
    @(posedge clk) disable iff (rst) exp_valid |-> (retire_illegal == exp_illegal)
  ) else report_mismatch("retire_illegal", xlen_t'($sampled(retire_illegal)),
                         xlen_t'(exp_illegal));

  a_retire_rd: assert property (
    @(posedge clk) disable iff (rst) exp_valid |-> (retire_rd == exp_rd)
  ) else report_mismatch("retire_rd", xlen_t'($sampled(retire_rd)), xlen_t'(exp_rd));

  a_retire_data: assert property (
    @(posedge clk) disable iff (rst) (exp_valid && !exp_illegal) |-> (retire_data == exp_data)
  ) else report_mismatch("retire_data", $sampled(retire_data), exp_data);

  // --------------------
  // ISA result for op codes 0 (add) through 9 (and). Other codes pass b.
  function automatic xlen_t isa_op(input int op, input xlen_t a, input xlen_t b);
    case (op)
      0: return a + b;
      1: return a - b;
      2: return a << b[5:0];
      3: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      4: return (a < b) ? 64'd1 : 64'd0;
      5: return a ^ b;
      6: return a >> b[5:0];
      7: return xlen_t'($signed(a) >>> b[5:0]);
      8: return a | b;
      9: return a & b;
      default: return b;
    endcase
  endfunction

  function automatic logic [2:0] funct3_of(input int op);
    case (op)
      0, 1:    return 3'b000;
      2:       return 3'b001;
      3:       return 3'b010;
      4:       return 3'b011;
      5:       return 3'b100;
      6, 7:    return 3'b101;
      8:       return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  // Immediate forms in the order addi slti sltiu xori ori andi slli srli srai.
  function automatic int imm_kind_op(input int kind);
    case (kind)
      10: return 0;
      11: return 3;
      12: return 4;
      13: return 5;
      14: return 8;
      15: return 9;
      16: return 2;
      17: return 6;
      default: return 7;
    endcase
  endfunction

  // Mostly x0..x4 so that dependencies show up often.
  function automatic reg_addr_t pick_reg();
    if ($urandom_range(0, 3) == 0) begin
      return reg_addr_t'($urandom_range(0, 31));
    end
    return reg_addr_t'($urandom_range(0, 4));
  endfunction

  task automatic drive_cycle(input logic v, input instr_t w, input logic ill,
                             input reg_addr_t rd, input xlen_t data);
    @(negedge clk);
    if (expected_q.size() > 0) begin
      {exp_valid, exp_illegal, exp_rd, exp_data} = expected_q.pop_front();
    end else begin
      exp_valid = 1'b0;
    end
    instr_valid = v;
    instr       = w;
    expected_q.push_back({v, ill, rd, data});
  endtask

  task automatic issue_random();
    int          kind;
    int          op;
    logic [31:0] rnd;
    logic [11:0] imm12;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    xlen_t       b;
    xlen_t       res;
    instr_t      w;
    kind = $urandom_range(0, 19);
    rnd  = $urandom;
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    if (kind < 10) begin
      op = kind;
      b  = shadow[rs2];
      w  = {(op == 1 || op == 7) ? 7'b0100000 : 7'b0, rs2, rs1, funct3_of(op), rd, 7'b0110011};
    end else if (kind < 19) begin
      op    = imm_kind_op(kind);
      imm12 = rnd[11:0];
      if (op == 2 || op == 6 || op == 7) begin
        imm12 = {(op == 7) ? 6'b010000 : 6'b0, rnd[5:0]};
      end
      b = {{52{imm12[11]}}, imm12};
      w = {imm12, rs1, funct3_of(op), rd, 7'b0010011};
    end else begin
      op = 10;
      b  = {{32{rnd[31]}}, rnd[31:12], 12'b0};
      w  = {rnd[31:12], rd, 7'b0110111};
    end
    res = isa_op(op, shadow[rs1], b);
    if (rd != '0) begin
      shadow[rd] = res;
    end
    drive_cycle(1'b1, w, 1'b0, rd, res);
  endtask

  task automatic issue_illegal();
    logic [31:0] rnd;
    reg_addr_t   rd;
    instr_t      w;
    rnd = $urandom;
    rd  = pick_reg();
    case ($urandom_range(0, 2))
      0:       w = {rnd[19:0], rd, 7'b0000011};
      1:       w = {7'b0000001, pick_reg(), pick_reg(), rnd[2:0], rd, 7'b0110011};
      default: w = {6'b010000, rnd[5:0], pick_reg(), 3'b001, rd, 7'b0010011};
    endcase
    drive_cycle(1'b1, w, 1'b1, rd, '0);
  endtask

  // --------------------
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Watchdog timeout: the run did not finish in time, %0d errors so far", error_count);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    exp_valid   = 1'b0;
    exp_illegal = 1'b0;
    exp_rd      = '0;
    exp_data    = '0;
    error_count = 0;
    void'($urandom(SEED));
    for (int r = 0; r < NUM_REGS; r++) begin
      shadow[r] = REG_RESET_VALUE;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Every register read right after reset.
    for (int r = 0; r < NUM_REGS; r++) begin
      drive_cycle(1'b1, {7'b0, reg_addr_t'(r), reg_addr_t'(r), 3'b110, 5'd0, 7'b0110011},
                  1'b0, '0, REG_RESET_VALUE);
    end

    for (int i = 0; i < N_INSTR; i++) begin
      if ($urandom_range(0, 7) == 0) begin
        drive_cycle(1'b0, instr_t'($urandom), 1'b0, '0, '0);
      end
      if ($urandom_range(0, 15) == 0) begin
        issue_illegal();
      end else begin
        issue_random();
      end
    end

    drive_cycle(1'b0, '0, 1'b0, '0, '0);
    drive_cycle(1'b0, '0, 1'b0, '0, '0);
    @(negedge clk);

    $display("Run complete: %0d errors", error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/rv64_pkg.sv
source/rv64_reg_file.sv
source/rv64_decoder.sv
source/rv64_alu.sv
source/rv64_exec_core.sv
dv/rv64_exec_core_tb.sv

// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
TOP      ?= rv64_exec_core_tb
FILELIST ?= vlog.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
PASS_MSG := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
